//--- files.f
alignPkg.sv
wbRegPkg.sv
cellLink.sv
scoreRegs.sv
targetFeeder.sv
swCell.sv
scoreCollector.sv
systolicAligner.sv
tbSystolicAligner_properties.sv
tbSystolicAligner.sv

//--- tbSystolicAligner.sv
// testbench for the aligner: clock, xorshift stimulus, table model, checks and watchdog
`default_nettype none

module tbSystolicAligner
    import alignPkg::*, wbRegPkg::*;
();

    localparam int QUERY_LEN = 8;
    localparam int MAX_TLEN  = 40;
    // targets over all tests, sizes the watchdog
    localparam int NUM_TARGETS   = 20 + 16 + 20 + 7;
    localparam int WATCHDOG_TIME = NUM_TARGETS * (MAX_TLEN + QUERY_LEN + 20) * 10 * 4 + 20000;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 wbCyc;
    logic                 wbStb;
    logic                 wbWe;
    logic [WB_ADR_W-1:0]  wbAdr;
    wbData_t              wbDatW;
    wbData_t              wbDatR;
    logic                 wbAck;
    base_t                queryIn [QUERY_LEN];
    logic [QUERY_LEN-1:0] queryEn;
    base_t                targetIn;
    logic                 targetInStart;
    logic                 targetInLast;
    logic                 targetInValid;
    score_t               targetInScore;
    logic                 targetInReady;
    score_t               score;
    pos_t                 scoreJ;
    logic                 scoreValid;
    logic                 scoreReady;

    // model state, mirrors what was written to the DUT
    logic [31:0] rngState = 32'h87f5f312;
    int          curMatch;
    int          curMismatch;
    int          curGap;
    base_t       qModel [QUERY_LEN];
    int          nEnabled;
    // pending target bases and the expected results in order
    base_t       strBase [$];
    bit          strStart [$];
    bit          strLast [$];
    int          strScore [$];
    int          expScore [$];
    int          expJ [$];

    systolicAligner #(
        .QUERY_LEN (QUERY_LEN)
    ) DUT (
        .clk           (clk),
        .rst           (rst),
        .wbCyc         (wbCyc),
        .wbStb         (wbStb),
        .wbWe          (wbWe),
        .wbAdr         (wbAdr),
        .wbDatW        (wbDatW),
        .wbDatR        (wbDatR),
        .wbAck         (wbAck),
        .queryIn       (queryIn),
        .queryEn       (queryEn),
        .targetIn      (targetIn),
        .targetInStart (targetInStart),
        .targetInLast  (targetInLast),
        .targetInValid (targetInValid),
        .targetInScore (targetInScore),
        .targetInReady (targetInReady),
        .score         (score),
        .scoreJ        (scoreJ),
        .scoreValid    (scoreValid),
        .scoreReady    (scoreReady)
    );

    always #5 clk = ~clk;

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic int randRange(input int lo, input int hi);
        return lo + int'(nextRand() % (hi - lo + 1));
    endfunction

    function automatic int maxOf(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    task automatic failStop(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped on first error");
    endtask

    task automatic checkEq(input string name, input logic signed [31:0] expected,
                           input logic signed [31:0] actual);
        if (actual !== expected) begin
            failStop($sformatf("FAIL %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    // one classic cycle, master holds the request until ack
    task automatic wbXfer(input logic [WB_ADR_W-1:0] adr, input logic we, input wbData_t dat,
                          output wbData_t rd);
        int waited;
        waited = 0;
        @(posedge clk);
        wbCyc  <= 1'b1;
        wbStb  <= 1'b1;
        wbWe   <= we;
        wbAdr  <= adr;
        wbDatW <= dat;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 8) begin
                failStop("wishbone ack never arrived");
            end
        end while (!wbAck);
        rd = wbDatR;
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe  <= 1'b0;
    endtask

    task automatic regWrite(input logic [WB_ADR_W-1:0] adr, input wbData_t dat);
        wbData_t unused;
        wbXfer(adr, 1'b1, dat, unused);
    endtask

    task automatic regRead(input logic [WB_ADR_W-1:0] adr, output wbData_t rd);
        wbXfer(adr, 1'b0, '0, rd);
    endtask

    task automatic setScores(input int m, input int mm, input int g);
        regWrite(REG_MATCH, wbData_t'(m));
        regWrite(REG_MISMATCH, wbData_t'(mm));
        regWrite(REG_GAP, wbData_t'(g));
        curMatch    = m;
        curMismatch = mm;
        curGap      = g;
    endtask

    // random query with only the first n bases enabled
    task automatic setQuery(input int n);
        logic [QUERY_LEN-1:0] mask;
        base_t b;
        mask = '0;
        @(posedge clk);
        for (int k = 0; k < QUERY_LEN; k++) begin
            b = base_t'(randRange(0, 3));
            queryIn[k] <= b;
            qModel[k] = b;
            mask[k] = (k < n);
        end
        queryEn <= mask;
        nEnabled = n;
    endtask

    ////////////////////
    // model
    ////////////////////

    // queue one random target and its expected result from the table rule
    task automatic addTarget(input int len, input int s0);
        base_t tgt [MAX_TLEN];
        int prevRow [MAX_TLEN+1];
        int curRow [MAX_TLEN+1];
        int sub;
        int best;
        int bestJ;
        for (int j = 0; j < len; j++) begin
            tgt[j] = base_t'(randRange(0, 3));
            strBase.push_back(tgt[j]);
            strStart.push_back(j == 0);
            strLast.push_back(j == len - 1);
            strScore.push_back(s0);
        end
        // row 0 seeded from the initial score
        for (int j = 0; j <= len; j++) begin
            prevRow[j] = s0 + j * curGap;
        end
        for (int i = 1; i <= nEnabled; i++) begin
            curRow[0] = s0 + i * curGap;
            for (int j = 1; j <= len; j++) begin
                sub = (qModel[i-1] == tgt[j-1]) ? curMatch : curMismatch;
                curRow[j] = maxOf(prevRow[j-1] + sub, prevRow[j] + curGap);
                curRow[j] = maxOf(curRow[j], curRow[j-1] + curGap);
            end
            prevRow = curRow;
        end
        // lowest column wins a tie
        best  = prevRow[1];
        bestJ = 0;
        for (int j = 2; j <= len; j++) begin
            if (prevRow[j] > best) begin
                best  = prevRow[j];
                bestJ = j - 1;
            end
        end
        expScore.push_back(best);
        expJ.push_back(bestJ);
    endtask

    ////////////////////
    // stream driver and output monitor
    ////////////////////

    // sends the queued bases and checks every accepted score until all are back
    task automatic runBatch(input string name, input bit gaps, input bit stalls);
        int idx;
        idx = 0;
        while (idx < strBase.size() || expScore.size() > 0) begin
            @(posedge clk);
            // a base counts only when ready was high
            if (targetInValid && targetInReady) begin
                idx++;
            end
            if (scoreValid && scoreReady) begin
                if (expScore.size() == 0) begin
                    failStop("a score arrived with no target outstanding");
                end else begin
                    checkEq({name, " score"}, expScore.pop_front(), score);
                    checkEq({name, " scoreJ"}, expJ.pop_front(), scoreJ);
                end
            end
            if (idx < strBase.size() && (!gaps || randRange(0, 3) != 0)) begin
                targetInValid <= 1'b1;
                targetIn      <= strBase[idx];
                targetInStart <= strStart[idx];
                targetInLast  <= strLast[idx];
                targetInScore <= score_t'(strScore[idx]);
            end else begin
                targetInValid <= 1'b0;
            end
            scoreReady <= stalls ? (randRange(0, 2) != 0) : 1'b1;
        end
        targetInValid <= 1'b0;
        scoreReady    <= 1'b1;
        strBase.delete();
        strStart.delete();
        strLast.delete();
        strScore.delete();
    endtask

    ////////////////////
    // watchdog
    ////////////////////

    initial begin
        #(WATCHDOG_TIME);
        failStop("timeout, the run did not finish in time");
    end

    ////////////////////
    // tests
    ////////////////////

    initial begin
        wbData_t rd;
        logic [31:0] val;
        logic [WB_ADR_W-1:0] adr;
        score_t low;
        rst           = 1'b1;
        wbCyc         = 1'b0;
        wbStb         = 1'b0;
        wbWe          = 1'b0;
        wbAdr         = '0;
        wbDatW        = '0;
        queryEn       = '0;
        targetIn      = '0;
        targetInStart = 1'b0;
        targetInLast  = 1'b0;
        targetInValid = 1'b0;
        targetInScore = '0;
        scoreReady    = 1'b1;
        for (int k = 0; k < QUERY_LEN; k++) begin
            queryIn[k] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // reset state and register readback with sign extension
        @(posedge clk);
        checkEq("reset scoreValid", 0, scoreValid);
        regRead(REG_STATUS, rd);
        checkEq("reset status", 0, rd);
        repeat (8) begin
            adr = randRange(0, 2);
            val = nextRand();
            low = val[SCORE_W-1:0];
            regWrite(adr, val);
            regRead(adr, rd);
            checkEq("score readback", low, rd);
        end
        regWrite(REG_STATUS, 32'hffff_ffff);
        regRead(REG_STATUS, rd);
        checkEq("status write ignored", 0, rd);

        // full query, back to back targets, several in flight
        setScores(randRange(1, 3), -randRange(1, 3), -randRange(1, 3));
        setQuery(QUERY_LEN);
        repeat (20) addTarget(randRange(1, MAX_TLEN), randRange(-100, 100));
        runBatch("back to back", 1'b0, 1'b0);

        // shorter queries through the enable prefix
        repeat (8) begin
            setQuery(randRange(1, QUERY_LEN));
            repeat (2) addTarget(randRange(1, MAX_TLEN), randRange(-100, 100));
            runBatch("partial query", 1'b0, 1'b0);
        end

        // input gaps and output back pressure
        setQuery(QUERY_LEN);
        repeat (20) addTarget(randRange(1, MAX_TLEN), randRange(-100, 100));
        runBatch("stalls", 1'b1, 1'b1);

        // busy while in flight, then new scores
        addTarget(12, randRange(-100, 100));
        fork
            runBatch("busy target", 1'b0, 1'b0);
            begin
                do begin
                    @(posedge clk);
                end while (!(targetInValid && targetInReady && targetInLast));
                regRead(REG_STATUS, rd);
                checkEq("status in flight", 1, rd);
            end
        join
        regRead(REG_STATUS, rd);
        checkEq("status after accept", 0, rd);
        setScores(randRange(1, 3), -randRange(1, 3), -randRange(1, 3));
        repeat (6) addTarget(randRange(1, MAX_TLEN), randRange(-100, 100));
        runBatch("new scores", 1'b0, 1'b0);

        // nothing more may come out
        repeat (QUERY_LEN + 4) begin
            @(posedge clk);
            if (scoreValid) begin
                failStop("an extra score appeared after the last target");
            end
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tbSystolicAligner_properties.sv
// concurrent checks on the wishbone ack, the output buffer hold and the reset state
`default_nettype none

module tbSystolicAligner_properties
    import alignPkg::*;
(
    input logic   clk,
    input logic   rst,
    input logic   wbCyc,
    input logic   wbStb,
    input logic   wbAck,
    input logic   busy,
    input score_t score,
    input pos_t   scoreJ,
    input logic   scoreValid,
    input logic   scoreReady
);

    ////////////////////
    // wishbone
    ////////////////////

    // ack answers a strobe seen on the previous edge
    ackAfterStrobe: assert property (@(posedge clk) disable iff (rst)
        wbAck |-> $past(wbCyc && wbStb))
        else $error("wishbone ack without a request");

    // single cycle ack
    ackOneCycle: assert property (@(posedge clk) disable iff (rst)
        wbAck |=> !wbAck)
        else $error("wishbone ack held for two cycles");

    ////////////////////
    // output buffer
    ////////////////////

    // a waiting score must not move
    scoreHold: assert property (@(posedge clk) disable iff (rst)
        scoreValid && !scoreReady |=> scoreValid && $stable(score) && $stable(scoreJ))
        else $error("score changed while waiting for ready");

    // first cycle out of reset
    resetState: assert property (@(posedge clk)
        $past(rst) && !rst |-> !scoreValid && !busy)
        else $error("output or busy set right after reset");

endmodule

bind systolicAligner tbSystolicAligner_properties uProps (
    .clk        (clk),
    .rst        (rst),
    .wbCyc      (wbCyc),
    .wbStb      (wbStb),
    .wbAck      (wbAck),
    .busy       (busy),
    .score      (score),
    .scoreJ     (scoreJ),
    .scoreValid (scoreValid),
    .scoreReady (scoreReady)
);

`default_nettype wire

//--- systolicAligner.sv
// top level aligner with register slave, feeder, cell array and collector
`default_nettype none

module systolicAligner
    import alignPkg::*, wbRegPkg::*;
#(
    parameter int QUERY_LEN = 8
) (
    input  logic                 clk,
    input  logic                 rst,

    // wishbone classic slave
    input  logic                 wbCyc,
    input  logic                 wbStb,
    input  logic                 wbWe,
    input  logic [WB_ADR_W-1:0]  wbAdr,
    input  wbData_t              wbDatW,
    output wbData_t              wbDatR,
    output logic                 wbAck,

    // query, held stable while busy
    input  base_t                queryIn [QUERY_LEN],
    input  logic [QUERY_LEN-1:0] queryEn,

    // target stream
    input  base_t                targetIn,
    input  logic                 targetInStart,
    input  logic                 targetInLast,
    input  logic                 targetInValid,
    input  score_t               targetInScore,
    output logic                 targetInReady,

    // result
    output score_t               score,
    output pos_t                 scoreJ,
    output logic                 scoreValid,
    input  logic                 scoreReady
);

    scoreSet_t scores;
    logic      advance;
    logic      scoreFull;
    logic      busy;

    // link k feeds cell k, link QUERY_LEN feeds the collector
    cellLink link [QUERY_LEN+1] ();

    scoreRegs uRegs (
        .clk    (clk),
        .rst    (rst),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (regAddr_e'(wbAdr)),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck),
        .busy   (busy),
        .scores (scores)
    );

    targetFeeder #(
        .QUERY_LEN (QUERY_LEN)
    ) uFeeder (
        .clk           (clk),
        .rst           (rst),
        .targetIn      (targetIn),
        .targetInStart (targetInStart),
        .targetInLast  (targetInLast),
        .targetInValid (targetInValid),
        .targetInScore (targetInScore),
        .targetInReady (targetInReady),
        .scoreFull     (scoreFull),
        .scores        (scores),
        .advance       (advance),
        .busy          (busy),
        .down          (link[0])
    );

    ////////////////////
    // cell array
    ////////////////////

    for (genvar k = 0; k < QUERY_LEN; k++) begin : gCell
        swCell uCell (
            .clk       (clk),
            .rst       (rst),
            .advance   (advance),
            .scores    (scores),
            .queryBase (queryIn[k]),
            .queryEn   (queryEn[k]),
            .up        (link[k]),
            .down      (link[k+1])
        );
    end

    scoreCollector uCollector (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .up         (link[QUERY_LEN]),
        .score      (score),
        .scoreJ     (scoreJ),
        .scoreValid (scoreValid),
        .scoreReady (scoreReady),
        .scoreFull  (scoreFull)
    );

endmodule

`default_nettype wire

//--- scoreCollector.sv
// best last-row score tracking and one-entry output buffer
`default_nettype none

module scoreCollector
    import alignPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   advance,
    cellLink.dst   up,
    output score_t score,
    output pos_t   scoreJ,
    output logic   scoreValid,
    input  logic   scoreReady,
    output logic   scoreFull
);

    // running best of the current target
    score_t best;
    pos_t   bestJ;
    // index of the previous column
    pos_t   col;

    // values including this beat
    pos_t   curCol;
    score_t nextBest;
    pos_t   nextJ;

    ////////////////////
    // tracking
    ////////////////////

    assign curCol = up.start ? pos_t'(0) : col + 1'b1;

    // strictly greater only, so the lowest column wins ties
    always_comb begin
        if (up.start || up.h > best) begin
            nextBest = up.h;
            nextJ    = curCol;
        end else begin
            nextBest = best;
            nextJ    = bestJ;
        end
    end

    // bubbles between targets update junk that the next start discards
    always_ff @(posedge clk) begin
        if (advance) begin
            col   <= curCol;
            best  <= nextBest;
            bestJ <= nextJ;
        end
    end

    ////////////////////
    // output buffer
    ////////////////////

    // holds the array while a score waits
    assign scoreFull = scoreValid && !scoreReady;

    always_ff @(posedge clk) begin
        if (advance && up.last) begin
            score  <= nextBest;
            scoreJ <= nextJ;
        end
    end

    // advance implies the buffer is free or being emptied
    always_ff @(posedge clk) begin
        if (rst) begin
            scoreValid <= 1'b0;
        end else if (advance && up.last) begin
            scoreValid <= 1'b1;
        end else if (scoreReady) begin
            scoreValid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- swCell.sv
// systolic scoring cell, one query base and one row of the table
`default_nettype none

module swCell
    import alignPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      advance,
    input  scoreSet_t scores,
    input  base_t     queryBase,
    input  logic      queryEn,
    cellLink.dst      up,
    cellLink.src      down
);

    // query base and enable held for the whole target
    base_t  qBase;
    logic   qEn;
    // H[i-1][j-1], the upstream value of the previous column
    score_t diag;

    // values in use on this beat
    base_t  curBase;
    logic   curEn;
    score_t diagUse;
    score_t leftUse;
    score_t rowBound;
    score_t subScore;
    score_t cellH;

    // signed three-way maximum
    function automatic score_t max3(input score_t a, input score_t b, input score_t c);
        score_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    ////////////////////
    // recurrence
    ////////////////////

    // start beat takes the fresh query base straight from the inputs
    assign curBase = up.start ? queryBase : qBase;
    assign curEn   = up.start ? queryEn : qEn;

    // H[i][0] of this row
    assign rowBound = up.bound + scores.gap;

    // column 1 uses the column-0 values as neighbours
    assign diagUse = up.start ? up.bound : diag;
    assign leftUse = up.start ? rowBound : down.h;

    assign subScore = (curBase == up.base) ? scores.match : scores.mismatch;

    assign cellH = max3(diagUse + subScore, up.h + scores.gap, leftUse + scores.gap);

    ////////////////////
    // registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            qEn        <= 1'b0;
            down.start <= 1'b0;
            down.last  <= 1'b0;
        end else if (advance) begin
            if (up.start) begin
                qEn <= queryEn;
            end
            down.start <= up.start;
            down.last  <= up.last;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            if (up.start) begin
                qBase <= queryBase;
            end
            down.base <= up.base;
            diag      <= up.h;
            // a disabled cell is a plain one-cycle delay
            if (curEn) begin
                down.h     <= cellH;
                down.bound <= rowBound;
            end else begin
                down.h     <= up.h;
                down.bound <= up.bound;
            end
        end
    end

endmodule

`default_nettype wire

//--- targetFeeder.sv
// target input handshake, array stall control, row-0 seeding and busy tracking
`default_nettype none

module targetFeeder
    import alignPkg::*;
#(
    parameter int QUERY_LEN = 8
) (
    input  logic      clk,
    input  logic      rst,
    input  base_t     targetIn,
    input  logic      targetInStart,
    input  logic      targetInLast,
    input  logic      targetInValid,
    input  score_t    targetInScore,
    output logic      targetInReady,
    input  logic      scoreFull,
    input  scoreSet_t scores,
    output logic      advance,
    output logic      busy,
    cellLink.src      down
);

    // enough for a target in every link plus the collector
    localparam int CNT_W = $clog2(QUERY_LEN + 3);

    typedef enum logic {
        IDLE,
        IN_TARGET
    } feedState_e;

    feedState_e state;
    // base handshake completes this cycle
    logic xfer;
    // shadow of the last marks on links 1..QUERY_LEN
    logic [QUERY_LEN-1:0] lastPipe;
    // targets entered and not yet captured
    logic [CNT_W-1:0] inFlight;
    logic enter;
    logic capture;

    ////////////////////
    // handshake and stall
    ////////////////////

    // only a held score blocks input
    assign targetInReady = !scoreFull;
    assign xfer = targetInValid && targetInReady;
    // idle bubbles drain the array, a gap inside a target freezes it
    assign advance = !scoreFull && (xfer || state == IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else if (xfer) begin
            if (targetInLast) begin
                state <= IDLE;
            end else if (targetInStart) begin
                state <= IN_TARGET;
            end
        end
    end

    ////////////////////
    // link 0
    ////////////////////

    // start and last are control, cleared on reset and on bubbles
    always_ff @(posedge clk) begin
        if (rst) begin
            down.start <= 1'b0;
            down.last  <= 1'b0;
        end else if (advance) begin
            down.start <= xfer && targetInStart;
            down.last  <= xfer && targetInLast;
        end
    end

    // row 0 of the table
    // H[0][0] is the initial score and each column adds one gap
    always_ff @(posedge clk) begin
        if (advance && xfer) begin
            down.base <= targetIn;
            if (targetInStart) begin
                down.bound <= targetInScore;
                down.h     <= targetInScore + scores.gap;
            end else begin
                down.h     <= down.h + scores.gap;
            end
        end
    end

    ////////////////////
    // busy
    ////////////////////

    assign enter   = xfer && targetInStart;
    // the collector captures when last leaves the final link
    assign capture = advance && lastPipe[QUERY_LEN-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            lastPipe <= '0;
        end else if (advance) begin
            lastPipe <= {lastPipe[QUERY_LEN-2:0], down.last};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            inFlight <= '0;
        end else if (enter && !capture) begin
            inFlight <= inFlight + 1'b1;
        end else if (capture && !enter) begin
            inFlight <= inFlight - 1'b1;
        end
    end

    assign busy = (inFlight != '0);

endmodule

`default_nettype wire

//--- scoreRegs.sv
// wishbone classic slave with the scoring registers and the busy status
`default_nettype none

module scoreRegs
    import alignPkg::*, wbRegPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      wbCyc,
    input  logic      wbStb,
    input  logic      wbWe,
    input  regAddr_e  wbAdr,
    input  wbData_t   wbDatW,
    output wbData_t   wbDatR,
    output logic      wbAck,
    input  logic      busy,
    output scoreSet_t scores
);

    // a new request is seen while no ack is pending
    logic request;

    // sign extension of a score to the bus width
    function automatic wbData_t sext(input score_t val);
        return {{(WB_DATA_W-SCORE_W){val[SCORE_W-1]}}, val};
    endfunction

    assign request = wbCyc && wbStb && !wbAck;

    ////////////////////
    // ack
    ////////////////////

    // single cycle ack, one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= request;
        end
    end

    ////////////////////
    // score registers
    ////////////////////

    // status and unknown addresses swallow the write
    always_ff @(posedge clk) begin
        if (rst) begin
            scores.match    <= score_t'(2);
            scores.mismatch <= score_t'(-1);
            scores.gap      <= score_t'(-1);
        end else if (request && wbWe) begin
            case (wbAdr)
                REG_MATCH:    scores.match    <= score_t'(wbDatW[SCORE_W-1:0]);
                REG_MISMATCH: scores.mismatch <= score_t'(wbDatW[SCORE_W-1:0]);
                REG_GAP:      scores.gap      <= score_t'(wbDatW[SCORE_W-1:0]);
                default: ;
            endcase
        end
    end

    // read data lines up with the ack
    always_ff @(posedge clk) begin
        if (request) begin
            case (wbAdr)
                REG_MATCH:    wbDatR <= sext(scores.match);
                REG_MISMATCH: wbDatR <= sext(scores.mismatch);
                REG_GAP:      wbDatR <= sext(scores.gap);
                REG_STATUS:   wbDatR <= {{(WB_DATA_W-1){1'b0}}, busy};
                default:      wbDatR <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- cellLink.sv
// interface for one column step between neighbouring array stages
`default_nettype none

interface cellLink
    import alignPkg::*;
    ();

    // target base of the current column
    base_t  base;
    // first column of a target
    logic   start;
    // final column of a target
    logic   last;
    // H value of the upstream row for this column
    score_t h;
    // column-0 value of the upstream row, only meaningful with start
    score_t bound;

    // upstream stage owns the registers
    modport src (
        output base, start, last, h, bound
    );

    // downstream stage only samples
    modport dst (
        input base, start, last, h, bound
    );

endinterface

`default_nettype wire

//--- wbRegPkg.sv
// wishbone data and address widths, register map enum and bus data type
`default_nettype none

package wbRegPkg;

    // classic wishbone slave, word addressed
    localparam int WB_DATA_W = 32;
    localparam int WB_ADR_W  = 4;

    // register map
    // status bit 0 is the busy flag, read only
    typedef enum logic [WB_ADR_W-1:0] {
        REG_MATCH    = 4'd0,
        REG_MISMATCH = 4'd1,
        REG_GAP      = 4'd2,
        REG_STATUS   = 4'd3
    } regAddr_e;

    typedef logic [WB_DATA_W-1:0] wbData_t;

endpackage

`default_nettype wire

//--- alignPkg.sv
// alignment widths plus the base, score, target position and scoring-set types
`default_nettype none

package alignPkg;

    ////////////////////
    // widths
    ////////////////////

    // one nucleotide per two bits
    localparam int BASE_W  = 2;
    // signed dynamic-programming score
    localparam int SCORE_W = 12;
    // target base index, enough for 1024-base targets
    localparam int POS_W   = 10;

    ////////////////////
    // types
    ////////////////////

    typedef logic [BASE_W-1:0] base_t;
    typedef logic signed [SCORE_W-1:0] score_t;
    typedef logic [POS_W-1:0] pos_t;

    // substitution and linear gap scores shared by the whole array
    // match is normally positive, the other two negative
    typedef struct packed {
        score_t match;
        score_t mismatch;
        score_t gap;
    } scoreSet_t;

endpackage

`default_nettype wire
